//--- splitter_pkg.sv
//--------------------------------------------------------------------------
// shared definitions for the write-request page splitter
// page and bus geometry, width typedefs, channel payload structs
// and the address-side state encoding
//--------------------------------------------------------------------------

package splitter_pkg;

    //--------------------------------------------------------------------------
    // geometry
    //--------------------------------------------------------------------------

    // memory page in bytes
    localparam int PAGE_SIZE  = 4096;
    // 128-bit data bus
    localparam int BEAT_BYTES = 16;

    //--------------------------------------------------------------------------
    // widths
    //--------------------------------------------------------------------------

    // byte address
    typedef logic [31:0]  addr_t;
    // byte length, requests up to 8192
    typedef logic [13:0]  len_t;
    // one raw data beat
    typedef logic [127:0] data_t;
    // beats per segment, 1 to 256
    typedef logic [8:0]   beat_cnt_t;

    //--------------------------------------------------------------------------
    // channel payloads
    //--------------------------------------------------------------------------

    // request in, segment out
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } addr_req_t;

    // framed output beat
    typedef struct packed {
        data_t data;
        logic  last;
    } data_beat_t;

    // address channel FSM
    typedef enum logic [0:0] {
        split_idle,
        split_seg
    } split_state_t;

endpackage

//--- reg_slice.sv
//--------------------------------------------------------------------------
// one-entry valid/ready register slice
// breaks the combinational path on an input channel
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module reg_slice #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    // low for the first cycle out of reset
    logic armed;
    logic in_xfer;

    // accept when empty or draining this cycle
    assign in_ready = armed && (!out_valid || out_ready);
    assign in_xfer  = in_valid && in_ready;

    // control side
    always_ff @(posedge clk) begin
        if (rst) begin
            armed     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (in_xfer) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                // output taken, nothing new behind it
                out_valid <= 1'b0;
            end
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out_data <= in_data;
        end
    end

endmodule

//--- seg_queue.sv
//--------------------------------------------------------------------------
// synchronous FIFO of segment beat counts
// address side pushes one entry per segment, data side pops at segment end
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module seg_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  splitter_pkg::beat_cnt_t push_beats,
    input  logic                    pop,
    output logic                    full,
    output logic                    empty,
    output splitter_pkg::beat_cnt_t head_beats
);
    import splitter_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    beat_cnt_t        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head visible the cycle after its push
    assign head_beats = mem[rd_ptr];

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_beats;
        end
    end

endmodule

//--- addr_splitter.sv
//--------------------------------------------------------------------------
// address channel FSM
// cuts each write request into one segment per 4 KiB page and
// pushes the beat count of every segment to the control queue
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module addr_splitter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  splitter_pkg::addr_req_t req,
    output logic                    seg_valid,
    input  logic                    seg_ready,
    output splitter_pkg::addr_req_t seg,
    input  logic                    q_full,
    output logic                    q_push,
    output splitter_pkg::beat_cnt_t q_beats
);
    import splitter_pkg::*;

    localparam int PAGE_W = $clog2(PAGE_SIZE);
    localparam int BEAT_W = $clog2(BEAT_BYTES);

    split_state_t state;
    split_state_t state_next;
    // start of the next page and bytes still to emit
    addr_t        next_addr;
    len_t         rem_len;
    len_t         room;
    logic         crosses;
    logic         last_seg;
    logic         accept;

    // bytes from request start to page end
    assign room     = len_t'(PAGE_SIZE) - len_t'(req.addr[PAGE_W-1:0]);
    assign crosses  = (req.len > room);
    assign last_seg = (rem_len <= len_t'(PAGE_SIZE));
    // segment goes out only with room in the queue too
    assign accept   = seg_ready && !q_full;

    //--------------------------------------------------------------------------
    // segment select and next state
    //--------------------------------------------------------------------------
    always_comb begin
        seg_valid  = 1'b0;
        seg        = req;
        req_ready  = 1'b0;
        state_next = state;
        case (state)
            split_idle: begin
                // first segment straight from the slice
                seg_valid = req_valid;
                if (crosses) begin
                    seg.len = room;
                end
                if (req_valid && accept) begin
                    if (crosses) begin
                        state_next = split_seg;
                    end else begin
                        req_ready = 1'b1;
                    end
                end
            end
            split_seg: begin
                // whole pages, then the remainder
                seg_valid = 1'b1;
                seg.addr  = next_addr;
                seg.len   = last_seg ? rem_len : len_t'(PAGE_SIZE);
                if (accept && last_seg) begin
                    // request fully covered, release it
                    req_ready  = 1'b1;
                    state_next = split_idle;
                end
            end
        endcase
    end

    assign q_push  = seg_valid && accept;
    // aligned length, so a plain shift
    assign q_beats = beat_cnt_t'(seg.len >> BEAT_W);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= split_idle;
        end else begin
            state <= state_next;
        end
    end

    // remainder bookkeeping per accepted segment
    always_ff @(posedge clk) begin
        if (q_push) begin
            next_addr <= seg.addr + addr_t'(seg.len);
            if (state == split_idle) begin
                rem_len <= req.len - seg.len;
            end else begin
                rem_len <= rem_len - seg.len;
            end
        end
    end

endmodule

//--- beat_framer.sv
//--------------------------------------------------------------------------
// data channel framer
// counts beats against the queue head and marks each segment end
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module beat_framer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  splitter_pkg::data_t      in_data,
    input  logic                     q_empty,
    output logic                     q_pop,
    input  splitter_pkg::beat_cnt_t  q_beats,
    output logic                     out_valid,
    input  logic                     out_ready,
    output splitter_pkg::data_beat_t out
);
    import splitter_pkg::*;

    // set while inside a segment
    logic      active;
    // beats left, current beat included
    beat_cnt_t cnt;
    beat_cnt_t cur_cnt;
    logic      last_beat;
    logic      xfer;

    // first beat of a segment reads the queue head
    assign cur_cnt   = active ? cnt : q_beats;
    assign last_beat = (cur_cnt == beat_cnt_t'(1));

    // no segment known, so hold the data
    assign out_valid = in_valid && !q_empty;
    assign in_ready  = out_ready && !q_empty;
    assign xfer      = out_valid && out_ready;

    assign out.data = in_data;
    assign out.last = last_beat;

    // segment done, drop its entry
    assign q_pop = xfer && last_beat;

    //--------------------------------------------------------------------------
    // beat counter
    //--------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (xfer) begin
            // back to head lookup after the last beat
            active <= !last_beat;
            cnt    <= cur_cnt - beat_cnt_t'(1);
        end
    end

endmodule

//--- wr_splitter_top.sv
//--------------------------------------------------------------------------
// write-request page splitter top level
// input slices, address splitter, control queue and data framer
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module wr_splitter_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    // request in
    input  logic                     req_valid,
    output logic                     req_ready,
    input  splitter_pkg::addr_req_t  req,
    // raw data in
    input  logic                     wdata_valid,
    output logic                     wdata_ready,
    input  splitter_pkg::data_t      wdata,
    // segments out
    output logic                     seg_valid,
    input  logic                     seg_ready,
    output splitter_pkg::addr_req_t  seg,
    // framed data out
    output logic                     out_valid,
    input  logic                     out_ready,
    output splitter_pkg::data_beat_t out
);
    import splitter_pkg::*;

    // slice to splitter
    logic      rq_valid;
    logic      rq_ready;
    addr_req_t rq;
    // splitter to queue
    logic      q_push;
    logic      q_full;
    beat_cnt_t q_push_beats;
    // queue to framer
    logic      q_pop;
    logic      q_empty;
    beat_cnt_t q_head_beats;
    // slice to framer
    logic      dq_valid;
    logic      dq_ready;
    data_t     dq;

    //--------------------------------------------------------------------------
    // address path
    //--------------------------------------------------------------------------
    reg_slice #(
        .WIDTH($bits(addr_req_t))
    ) req_slice (
        .clk      (clk),
        .rst      (rst),
        .in_valid (req_valid),
        .in_ready (req_ready),
        .in_data  (req),
        .out_valid(rq_valid),
        .out_ready(rq_ready),
        .out_data (rq)
    );

    addr_splitter i_addr_splitter (
        .clk      (clk),
        .rst      (rst),
        .req_valid(rq_valid),
        .req_ready(rq_ready),
        .req      (rq),
        .seg_valid(seg_valid),
        .seg_ready(seg_ready),
        .seg      (seg),
        .q_full   (q_full),
        .q_push   (q_push),
        .q_beats  (q_push_beats)
    );

    // address side may run QUEUE_DEPTH segments ahead
    seg_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_seg_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (q_push),
        .push_beats(q_push_beats),
        .pop       (q_pop),
        .full      (q_full),
        .empty     (q_empty),
        .head_beats(q_head_beats)
    );

    //--------------------------------------------------------------------------
    // data path
    //--------------------------------------------------------------------------
    reg_slice #(
        .WIDTH($bits(data_t))
    ) data_slice (
        .clk      (clk),
        .rst      (rst),
        .in_valid (wdata_valid),
        .in_ready (wdata_ready),
        .in_data  (wdata),
        .out_valid(dq_valid),
        .out_ready(dq_ready),
        .out_data (dq)
    );

    beat_framer i_beat_framer (
        .clk      (clk),
        .rst      (rst),
        .in_valid (dq_valid),
        .in_ready (dq_ready),
        .in_data  (dq),
        .q_empty  (q_empty),
        .q_pop    (q_pop),
        .q_beats  (q_head_beats),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out      (out)
    );

endmodule

//--- wr_splitter_checker.sv
//--------------------------------------------------------------------------
// protocol checker bound into the splitter top level
// output channel hold under stall, page containment, segment length rules
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module wr_splitter_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     seg_valid,
    input logic                     seg_ready,
    input splitter_pkg::addr_req_t  seg,
    input logic                     q_full,
    input logic                     out_valid,
    input logic                     out_ready,
    input splitter_pkg::data_beat_t out
);
    import splitter_pkg::*;

    // segment leaves only with room in the control queue
    logic        seg_xfer;
    // page offset plus length, one bit of headroom
    logic [14:0] seg_end;

    assign seg_xfer = seg_valid && seg_ready && !q_full;
    assign seg_end  = {3'b000, seg.addr[11:0]} + {1'b0, seg.len};

    // stalled segment stays put
    seg_hold: assert property (@(posedge clk) disable iff (rst)
        seg_valid && !seg_xfer |=> seg_valid && $stable(seg))
        else $error("segment channel changed while stalled");

    // stalled beat stays put, last flag included
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("data output changed while stalled");

    // never past the end of the page
    seg_in_page: assert property (@(posedge clk) disable iff (rst)
        seg_valid |-> seg_end <= 15'(PAGE_SIZE))
        else $error("segment crosses a page boundary");

    seg_len_ok: assert property (@(posedge clk) disable iff (rst)
        seg_valid |-> (seg.len != '0) && (seg.len[3:0] == 4'd0))
        else $error("segment length is zero or not a multiple of 16");

endmodule

bind wr_splitter_top wr_splitter_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .seg_valid(seg_valid),
    .seg_ready(seg_ready),
    .seg      (seg),
    .q_full   (q_full),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out      (out)
);

//--- tb_wr_splitter.sv
//--------------------------------------------------------------------------
// testbench for the write-request page splitter
// random aligned requests and data, random back-pressure,
// reference model of segments and framed beats
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_wr_splitter;
    import splitter_pkg::*;

    localparam int NUM_REQS    = 60;
    localparam int WAIT_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 400000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    addr_req_t  req;
    logic       wdata_valid;
    logic       wdata_ready;
    data_t      wdata;
    logic       seg_valid;
    logic       seg_ready;
    addr_req_t  seg;
    logic       out_valid;
    logic       out_ready;
    data_beat_t out;

    integer     seed;
    int         cyc;
    // stimulus and expected responses
    addr_req_t  req_list[$];
    data_t      data_list[$];
    addr_req_t  exp_segs[$];
    data_beat_t exp_beats[$];
    addr_req_t  seg_exp;
    data_beat_t beat_exp;
    int         seg_total;
    int         beat_total;
    int         seg_seen;
    int         beat_seen;
    int         drain_t;

    wr_splitter_top #(.QUEUE_DEPTH(8)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    //--------------------------------------------------------------------------
    // reference model
    //--------------------------------------------------------------------------
    task automatic build_model();
        addr_req_t  r;
        addr_req_t  s;
        data_beat_t b;
        addr_t      a;
        int         n;
        int         rem;
        int         room;
        int         seg_len;
        for (int i = 0; i < NUM_REQS; i++) begin
            r.addr = addr_t'($random(seed)) & ~addr_t'(15);
            // half short requests, half up to two pages
            if (($random(seed) & 1) != 0) begin
                n = ($random(seed) & 15) + 1;
            end else begin
                n = ($random(seed) & 511) + 1;
            end
            r.len = len_t'(n * BEAT_BYTES);
            req_list.push_back(r);
            a   = r.addr;
            rem = n * BEAT_BYTES;
            // each piece ends at the page end or the request end
            while (rem > 0) begin
                room    = PAGE_SIZE - int'(a[11:0]);
                seg_len = (rem < room) ? rem : room;
                s.addr  = a;
                s.len   = len_t'(seg_len);
                exp_segs.push_back(s);
                for (int k = seg_len / BEAT_BYTES; k > 0; k--) begin
                    b.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
                    b.last = (k == 1);
                    exp_beats.push_back(b);
                    data_list.push_back(b.data);
                end
                a   = a + addr_t'(seg_len);
                rem = rem - seg_len;
            end
        end
    endtask

    //--------------------------------------------------------------------------
    // input drivers, falling edge
    //--------------------------------------------------------------------------
    task automatic drive_reqs();
        int t;
        while (req_list.size() > 0) begin
            repeat ($random(seed) & 3) @(negedge clk);
            req_valid = 1'b1;
            req       = req_list.pop_front();
            t         = 0;
            do begin
                @(posedge clk);
                t++;
                assert (t < WAIT_LIMIT)
                    else abort_run("timeout waiting for req_ready");
            end while (!req_ready);
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic drive_data();
        int t;
        while (data_list.size() > 0) begin
            repeat ($random(seed) & 1) @(negedge clk);
            wdata_valid = 1'b1;
            wdata       = data_list.pop_front();
            t           = 0;
            do begin
                @(posedge clk);
                t++;
                assert (t < WAIT_LIMIT)
                    else abort_run("timeout waiting for wdata_ready");
            end while (!wdata_ready);
            @(negedge clk);
            wdata_valid = 1'b0;
        end
    endtask

    // random ready, long out_ready stalls fill the queue
    always @(negedge clk) begin
        seg_ready = (($random(seed) & 3) != 0);
        out_ready = ((cyc % 300) >= 80) && (($random(seed) & 1) != 0);
        cyc       = cyc + 1;
    end

    //--------------------------------------------------------------------------
    // output monitors, rising edge
    //--------------------------------------------------------------------------
    // segment counts only when the control queue takes it too
    always @(posedge clk) begin
        if (!rst && seg_valid && seg_ready && !i_dut.q_full) begin
            assert (exp_segs.size() > 0)
                else abort_run("segment output with no segment left in the model");
            seg_exp = exp_segs.pop_front();
            assert (seg.addr == seg_exp.addr)
                else abort_run($sformatf("CHECK FAILED: seg.addr got %h expected %h",
                                         seg.addr, seg_exp.addr));
            assert (seg.len == seg_exp.len)
                else abort_run($sformatf("CHECK FAILED: seg.len got %h expected %h",
                                         seg.len, seg_exp.len));
            seg_seen++;
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_beats.size() > 0)
                else abort_run("output beat with no beat left in the model");
            beat_exp = exp_beats.pop_front();
            assert (out.data == beat_exp.data)
                else abort_run($sformatf("CHECK FAILED: out.data got %h expected %h",
                                         out.data, beat_exp.data));
            assert (out.last == beat_exp.last)
                else abort_run($sformatf("CHECK FAILED: out.last got %h expected %h",
                                         out.last, beat_exp.last));
            beat_seen++;
        end
    end

    //--------------------------------------------------------------------------
    // main sequence
    //--------------------------------------------------------------------------
    initial begin
        seed        = 32'heb03;
        cyc         = 0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        seg_ready   = 1'b0;
        out_ready   = 1'b0;
        seg_seen    = 0;
        beat_seen   = 0;
        build_model();
        seg_total  = exp_segs.size();
        beat_total = exp_beats.size();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // first cycle out of reset
        assert (!seg_valid && !out_valid)
            else abort_run("seg_valid or out_valid high right after reset");
        // both input slices still closed
        assert (!req_ready && !wdata_ready)
            else abort_run("req_ready or wdata_ready high right after reset");
        fork
            drive_reqs();
            drive_data();
        join
        drain_t = 0;
        while (seg_seen < seg_total || beat_seen < beat_total) begin
            @(posedge clk);
            drain_t++;
            assert (drain_t < DRAIN_LIMIT)
                else abort_run("timeout waiting for all segments and beats");
        end
        // late extra outputs would hit the monitors here
        repeat (50) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- compile.f
splitter_pkg.sv
reg_slice.sv
seg_queue.sv
addr_splitter.sv
beat_framer.sv
wr_splitter_top.sv
wr_splitter_checker.sv
tb_wr_splitter.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the page splitter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_wr_splitter -o sim_wr_splitter \
    && ./obj_dir/sim_wr_splitter \
    || { echo "simulation did not pass"; exit 1; }
